/* hdl/burstPkg.sv */
`default_nettype none

package burstPkg;

    // word and address sizing
    localparam int DATA_WIDTH = 16;
    localparam int DEPTH_LOG2 = 5;

    // regular drain size
    localparam int BURST_LEN = 8;

    // idle cycles before a short tail gets pushed out
    localparam int FLUSH_TIMEOUT = 48;
    localparam int TIMER_WIDTH = 6;

    typedef enum logic [1:0] {
        IDLE,
        BURST,
        FLUSH
    } drainState;

endpackage

`default_nettype wire

/* hdl/fifoMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module fifoMemory (
    input  logic                            clk,
    input  logic                            writeEnable,
    input  logic [burstPkg::DEPTH_LOG2-1:0] writeAddr,
    input  logic [burstPkg::DATA_WIDTH-1:0] dataIn,
    input  logic [burstPkg::DEPTH_LOG2-1:0] readAddr,
    output logic [burstPkg::DATA_WIDTH-1:0] dataOut
);
    import burstPkg::*;

    logic [DATA_WIDTH-1:0] memory [(1 << DEPTH_LOG2)-1:0];

    // retimed write path, one stage ahead of the array
    logic [DEPTH_LOG2-1:0] writeAddrReg;
    logic [DATA_WIDTH-1:0] writeDataReg;
    logic                  writeEnableReg;

    always_ff @(posedge clk) begin
        writeAddrReg   <= writeAddr;
        writeDataReg   <= dataIn;
        writeEnableReg <= writeEnable;
    end

    always_ff @(posedge clk) begin
        if (writeEnableReg) begin
            memory[writeAddrReg] <= writeDataReg;
        end
    end

    // unregistered read, like an MLAB in show-ahead mode
    // reading the slot under write is not defined here
    assign dataOut = memory[readAddr];

endmodule

`default_nettype wire

/* hdl/fastFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fastFifo (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            writeEnable,
    input  logic [burstPkg::DATA_WIDTH-1:0] dataIn,
    input  logic                            readRequest,
    output logic [burstPkg::DATA_WIDTH-1:0] dataOut,
    output logic                            dataOutValid,
    output logic [burstPkg::DEPTH_LOG2-1:0] level,
    output logic                            hasData,
    output logic                            full
);
    import burstPkg::*;

    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;
    logic [DEPTH_LOG2-1:0] validUpTo;
    logic [DEPTH_LOG2-1:0] writeNext;
    logic [DEPTH_LOG2-1:0] rawUsed;
    logic                  accepted;
    logic                  isReading;

    // one slot stays free, so full is writeNext catching up with readPtr
    assign writeNext = writePtr + 1'b1;
    assign full      = writeNext == readPtr;
    assign accepted  = writeEnable && !full;

    // what the reader may see lags the writer by the memory write latency
    assign level     = validUpTo - readPtr;
    assign hasData   = validUpTo != readPtr;
    assign rawUsed   = writePtr - readPtr;

    assign isReading    = readRequest && hasData;
    assign dataOutValid = isReading;

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr  <= '0;
            readPtr   <= '0;
            validUpTo <= '0;
        end else begin
            if (accepted) begin
                writePtr <= writeNext;
            end
            if (isReading) begin
                readPtr <= readPtr + 1'b1;
            end
            validUpTo <= writePtr;
        end
    end

    fifoMemory u_mem (
        .clk         (clk),
        .writeEnable (accepted),
        .writeAddr   (writePtr),
        .dataIn      (dataIn),
        .readAddr    (readPtr),
        .dataOut     (dataOut)
    );

    // the drain side must only pull when something is visible
    assertReadHasData: assert property (
        @(posedge clk) disable iff (rst) readRequest |-> hasData
    );

    // a level that wrapped past 31 would exceed the raw occupancy
    assertLevelBound: assert property (
        @(posedge clk) disable iff (rst) level <= rawUsed
    );

endmodule

`default_nettype wire

/* hdl/flushTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module flushTimer (
    input  logic clk,
    input  logic rst,
    input  logic writeEnable,
    input  logic full,
    input  logic hasData,
    input  logic drainStart,
    output logic expired
);
    import burstPkg::*;

    logic [TIMER_WIDTH-1:0] idleCount;
    logic                   restart;

    // fresh data or a new drain means the tail is not stale yet
    assign restart = (writeEnable && !full) || drainStart || !hasData;
    assign expired = idleCount == TIMER_WIDTH'(FLUSH_TIMEOUT);

    always_ff @(posedge clk) begin
        if (rst) begin
            idleCount <= '0;
        end else if (restart) begin
            idleCount <= '0;
        end else if (!expired) begin
            idleCount <= idleCount + 1'b1;
        end
    end

    // idle count stops at the timeout
    assertTimerBound: assert property (
        @(posedge clk) disable iff (rst)
        idleCount <= TIMER_WIDTH'(FLUSH_TIMEOUT)
    );

endmodule

`default_nettype wire

/* hdl/drainControl.sv */
`timescale 1ns/1ps
`default_nettype none

module drainControl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            drainHold,
    input  logic [burstPkg::DEPTH_LOG2-1:0] level,
    input  logic                            expired,
    output logic                            readRequest,
    output logic                            drainStart,
    output logic                            outLast
);
    import burstPkg::*;

    drainState             state;
    logic [DEPTH_LOG2-1:0] remaining;
    logic                  startBurst;
    logic                  startFlush;
    logic                  lastWord;

    // a full burst wins over a pending flush
    assign startBurst = !drainHold && (level >= DEPTH_LOG2'(BURST_LEN));
    assign startFlush = !drainHold && expired;

    assign drainStart = (state == IDLE) && (startBurst || startFlush);

    // one word per cycle for as long as a drain runs
    assign readRequest = state != IDLE;
    assign lastWord    = remaining == DEPTH_LOG2'(1);
    assign outLast     = readRequest && lastWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (startBurst) begin
                        state     <= BURST;
                        remaining <= DEPTH_LOG2'(BURST_LEN);
                    end else if (startFlush) begin
                        state     <= FLUSH;
                        remaining <= level;
                    end
                end
                BURST, FLUSH: begin
                    remaining <= remaining - 1'b1;
                    if (lastWord) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a regular burst ends exactly BURST_LEN cycles after its start
    assertBurstLength: assert property (
        @(posedge clk) disable iff (rst)
        outLast && (state == BURST) |-> $past(drainStart, BURST_LEN)
    );

    // reads never begin without a start decision the cycle before
    assertReadAfterStart: assert property (
        @(posedge clk) disable iff (rst)
        $rose(readRequest) |-> $past(drainStart)
    );

endmodule

`default_nettype wire

/* hdl/burstBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module burstBuffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            writeEnable,
    input  logic [burstPkg::DATA_WIDTH-1:0] dataIn,
    input  logic                            drainHold,
    output logic                            full,
    output logic                            outValid,
    output logic [burstPkg::DATA_WIDTH-1:0] outData,
    output logic                            outLast,
    output logic [burstPkg::DEPTH_LOG2-1:0] level
);

    logic hasData;
    logic readRequest;
    logic drainStart;
    logic expired;

    // the FIFO drops writes while full, so writeEnable goes in raw
    fastFifo u_fifo (
        .clk          (clk),
        .rst          (rst),
        .writeEnable  (writeEnable),
        .dataIn       (dataIn),
        .readRequest  (readRequest),
        .dataOut      (outData),
        .dataOutValid (outValid),
        .level        (level),
        .hasData      (hasData),
        .full         (full)
    );

    flushTimer u_timer (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .full        (full),
        .hasData     (hasData),
        .drainStart  (drainStart),
        .expired     (expired)
    );

    drainControl u_drain (
        .clk         (clk),
        .rst         (rst),
        .drainHold   (drainHold),
        .level       (level),
        .expired     (expired),
        .readRequest (readRequest),
        .drainStart  (drainStart),
        .outLast     (outLast)
    );

endmodule

`default_nettype wire

/* test/burstBufferTb.sv */
`timescale 1ns/1ps
`default_nettype none

module burstBufferTb;
    import burstPkg::*;

    localparam int NUM_ROWS = 5;
    localparam int WAIT_LIMIT = 400;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  writeEnable;
    logic [DATA_WIDTH-1:0] dataIn;
    logic                  drainHold;
    logic                  full;
    logic                  outValid;
    logic [DATA_WIDTH-1:0] outData;
    logic                  outLast;
    logic [DEPTH_LOG2-1:0] level;

    // count, gap, hold, settle, groups, last group size, words left, full, tail idle
    int stimTable [NUM_ROWS][9] = '{
        '{24, 2, 0, 40, 3, 8, 0, 0, 0},
        '{13, 0, 0, 40, 2, 5, 0, 0, 1},
        '{40, 0, 1, 80, 0, 0, 31, 1, 0},
        '{0, 0, 0, 40, 4, 7, 0, 0, 0},
        '{40, 0, 0, 40, 5, 8, 0, 0, 0}
    };

    logic [DATA_WIDTH-1:0] expectedQ [$];
    int                    groupSizes [$];
    logic [DATA_WIDTH-1:0] expWord;
    logic [31:0]           rngState = 32'd41;
    int                    cycle = 0;
    int                    wordsSinceLast = 0;
    int                    groupStart = 0;
    int                    lastWriteCycle = 0;
    int                    mismatchCount = 0;
    int                    otherCount = 0;

    burstBuffer u_burstBuffer (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .dataIn      (dataIn),
        .drainHold   (drainHold),
        .full        (full),
        .outValid    (outValid),
        .outData     (outData),
        .outLast     (outLast),
        .level       (level)
    );

    always #20 clk = ~clk;

    function automatic logic [DATA_WIDTH-1:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState[DATA_WIDTH-1:0];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            mismatchCount++;
        end
    endtask

    // output side, compared in write order
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst && outValid) begin
            if (expectedQ.size() == 0) begin
                $display("output word 0x%0h came out with no word left to expect", outData);
                otherCount++;
            end else begin
                expWord = expectedQ.pop_front();
                checkValue("outData", expWord, outData);
            end
            if (wordsSinceLast == 0) begin
                groupStart = cycle;
            end
            wordsSinceLast++;
            if (outLast) begin
                groupSizes.push_back(wordsSinceLast);
                wordsSinceLast = 0;
            end
        end else if (!rst) begin
            checkValue("outLast", 0, outLast);
        end
    end

    task automatic checkIdleAfterReset();
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            checkValue("outValid", 0, outValid);
            checkValue("outLast", 0, outLast);
            checkValue("full", 0, full);
            checkValue("level", 0, level);
        end
    endtask

    // a write counts only if full was low when it was presented
    task automatic writeWords(input int count, input int gap);
        int i;
        int g;
        logic [DATA_WIDTH-1:0] word;
        for (i = 0; i < count; i++) begin
            @(negedge clk);
            word = nextRandom();
            writeEnable = 1'b1;
            dataIn = word;
            if (!full) begin
                expectedQ.push_back(word);
                lastWriteCycle = cycle;
            end
            for (g = 0; g < gap; g++) begin
                @(negedge clk);
                writeEnable = 1'b0;
            end
        end
        @(negedge clk);
        writeEnable = 1'b0;
    endtask

    task automatic waitForDrain(input int row, input int queueLeft);
        int waited;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            if (expectedQ.size() == queueLeft && wordsSinceLast == 0 && !outValid) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        if (!done) begin
            $display("row %0d never drained down to %0d words in time", row, queueLeft);
            otherCount++;
        end
    endtask

    task automatic runRow(input int row);
        int count;
        int gap;
        int settle;
        int expGroups;
        int expLast;
        int expQueue;
        int i;
        logic hold;
        logic expFull;
        logic tailIdle;
        count = stimTable[row][0];
        gap = stimTable[row][1];
        hold = stimTable[row][2] != 0;
        settle = stimTable[row][3];
        expGroups = stimTable[row][4];
        expLast = stimTable[row][5];
        expQueue = stimTable[row][6];
        expFull = stimTable[row][7] != 0;
        tailIdle = stimTable[row][8] != 0;
        groupSizes.delete();
        @(negedge clk);
        drainHold = hold;
        writeWords(count, gap);
        waitForDrain(row, expQueue);
        repeat (settle) @(negedge clk);
        checkValue("groupCount", expGroups, groupSizes.size());
        for (i = 0; i < groupSizes.size(); i++) begin
            checkValue("groupSize", (i == groupSizes.size() - 1) ? expLast : BURST_LEN,
                       groupSizes[i]);
        end
        checkValue("queueSize", expQueue, expectedQ.size());
        checkValue("level", expQueue, level);
        checkValue("full", expFull, full);
        // a flushed tail may only leave after the idle timeout
        if (tailIdle && groupStart - lastWriteCycle <= FLUSH_TIMEOUT) begin
            $display("row %0d flushed its tail after only %0d idle cycles", row,
                     groupStart - lastWriteCycle);
            otherCount++;
        end
    endtask

    initial begin
        int r;
        rst = 1'b1;
        writeEnable = 1'b0;
        dataIn = '0;
        drainHold = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkIdleAfterReset();
        for (r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
        end
        $display("errors: %0d value mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* burstBuffer.f */
hdl/burstPkg.sv
hdl/fifoMemory.sv
hdl/fastFifo.sv
hdl/flushTimer.sv
hdl/drainControl.sv
hdl/burstBuffer.sv
test/burstBufferTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f burstBuffer.f --top-module burstBufferTb -o simBurstBuffer

./obj_dir/simBurstBuffer > sim.log 2>&1 || {
    cat sim.log
    echo "simulation exited with an error"
    exit 1
}
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
